//--- hdl/pma_rx_settings.svh
// widths, idle character, register address width and lock counter default for the rx PHY
`ifndef PMA_RX_SETTINGS_SVH
`define PMA_RX_SETTINGS_SVH

// ------------------------------
// datapath
// ------------------------------
`define PMA_WORD_W      64              // parallel word from the transceiver
`define PMA_CHAR_W      10              // 8b10b encoded character
`define PMA_D21_5       10'b10_1010_1010 // alternating pattern used as idle
`define PMA_IDLE_CHARS  4               // idle chars in the 8G fill, rest is zero

// ------------------------------
// registers and lock
// ------------------------------
`define PMA_ADDR_W      4
`define PMA_LOCK_BITS   24              // roughly 8M cycles of hunting at full size

`endif

//--- hdl/pma_rx_types_pkg.sv
// datapath types: parallel word, rate select, status bundle and lock states
`include "pma_rx_settings.svh"

package pma_rx_types_pkg;

    // raw 64-bit word as delivered by the PMA
    typedef logic [`PMA_WORD_W-1:0] pma_word_t;

    // decoded from data_rate[2]
    typedef enum logic {
        rate_8g  = 1'b0,
        rate_16g = 1'b1
    } pma_rate_e;

    // link status as seen by the register block and the output gating
    typedef struct packed {
        logic      locked;    // bit 2
        logic      los;       // bit 1
        pma_rate_e rate;      // bit 0
    } pma_status_t;

    // lock qualifier states
    typedef enum logic {
        lock_hunt = 1'b0,
        lock_done = 1'b1
    } pma_lock_state_e;

endpackage

//--- hdl/pma_rx_regs_pkg.sv
// register map types: address decode and control bits
`include "pma_rx_settings.svh"

package pma_rx_regs_pkg;

    // ------------------------------
    // address map
    // ------------------------------
    typedef enum logic [`PMA_ADDR_W-1:0] {
        reg_ctl     = 4'd0,
        reg_status  = 4'd1,     // read only
        reg_scratch = 4'd2
    } pma_reg_addr_e;

    // ------------------------------
    // control register layout
    // ------------------------------
    // sits in the low bits of reg_ctl, bit 0 is rx_invert
    typedef struct packed {
        logic lock_restart;     // forces the lock qualifier back to hunt
        logic rx_invert;        // xor'd with the polarity pin
    } pma_ctl_t;

endpackage

//--- hdl/pma_rx_sync.sv
// two-flop level synchronizer with configurable width and reset value
`timescale 1ns/1ps

module pma_rx_sync #(
    parameter int               width       = 1,
    parameter logic [width-1:0] reset_value = '0
) (
    input  logic             rx_pma_clkout,
    input  logic             rx_rst_n,
    input  logic [width-1:0] in_level,
    output logic [width-1:0] out_level
);

    logic [width-1:0] meta_q;   // first stage, may go metastable

    always_ff @(posedge rx_pma_clkout or negedge rx_rst_n) begin
        if (!rx_rst_n) begin
            meta_q    <= reset_value;
            out_level <= reset_value;
        end else begin
            meta_q    <= in_level;
            out_level <= meta_q;    // settled copy
        end
    end

endmodule

//--- hdl/pma_rx_lock_qual.sv
// lock-to-data qualifier: hunt counter and two-state FSM
`timescale 1ns/1ps

module pma_rx_lock_qual #(
    parameter int lock_bits = 24
) (
    input  logic                      rx_pma_clkout,
    input  logic                      rx_rst_n,
    input  logic                      loslock,    // synced transceiver reset
    input  pma_rx_regs_pkg::pma_ctl_t ctl,
    output logic                      locked
);

    pma_rx_types_pkg::pma_lock_state_e state_q;
    logic [lock_bits-1:0]              hunt_cnt_q;
    logic                              hold;

    // any reset of the transceiver or a sw restart throws away the lock
    assign hold = loslock | ctl.lock_restart;

    always_ff @(posedge rx_pma_clkout or negedge rx_rst_n) begin
        if (!rx_rst_n) begin
            state_q    <= pma_rx_types_pkg::lock_hunt;
            hunt_cnt_q <= '0;
        end else if (hold) begin
            state_q    <= pma_rx_types_pkg::lock_hunt;
            hunt_cnt_q <= '0;
        end else if (state_q == pma_rx_types_pkg::lock_hunt) begin
            if (hunt_cnt_q[lock_bits-1]) begin
                state_q <= pma_rx_types_pkg::lock_done;    // counter frozen from here
            end else begin
                hunt_cnt_q <= hunt_cnt_q + 1'b1;
            end
        end
    end

    assign locked = (state_q == pma_rx_types_pkg::lock_done);

    // ------------------------------
    // checks
    // ------------------------------
    // hold must knock lock down on the very next edge
    a_hold_drops_lock : assert property (
        @(posedge rx_pma_clkout) disable iff (!rx_rst_n)
        hold |=> !locked
    ) else $error("locked still high one cycle after hold");

endmodule

//--- hdl/pma_rx_datapath.sv
// receive pipeline: capture, polarity inversion, rate steering with gating
`timescale 1ns/1ps
`include "pma_rx_settings.svh"

module pma_rx_datapath (
    input  logic                           rx_pma_clkout,
    input  logic                           rx_rst_n,
    input  pma_rx_types_pkg::pma_word_t    rx_data_phy,
    input  pma_rx_regs_pkg::pma_ctl_t      ctl,
    input  logic                           invert_pin,
    input  pma_rx_types_pkg::pma_status_t  status,
    output pma_rx_types_pkg::pma_word_t    rx_pma_parallel_data,   // 16G
    output pma_rx_types_pkg::pma_word_t    rx_parallel_data_pma    // 8G
);

    localparam int fill_pad = `PMA_WORD_W - `PMA_IDLE_CHARS * `PMA_CHAR_W;

    // four D21.5 in the low 40 bits, top 24 zero
    localparam pma_rx_types_pkg::pma_word_t idle_fill =
        {{fill_pad{1'b0}}, {`PMA_IDLE_CHARS{`PMA_D21_5}}};

    pma_rx_types_pkg::pma_word_t cap_q;    // stage 1
    pma_rx_types_pkg::pma_word_t inv_q;    // stage 2
    logic                        gate_16g;
    logic                        gate_8g;
    logic                        link_bad;

    // ------------------------------
    // stages 1 and 2
    // ------------------------------
    always_ff @(posedge rx_pma_clkout) begin
        cap_q <= rx_data_phy;
        inv_q <= (ctl.rx_invert ^ invert_pin) ? ~cap_q : cap_q;   // both set cancel out
    end

    // gating terms
    assign link_bad = !status.locked || status.los;
    assign gate_16g = link_bad || (status.rate != pma_rx_types_pkg::rate_16g);
    assign gate_8g  = link_bad || (status.rate != pma_rx_types_pkg::rate_8g);

    // ------------------------------
    // stage 3, output steering
    // ------------------------------
    // comes out of reset already gated
    always_ff @(posedge rx_pma_clkout or negedge rx_rst_n) begin
        if (!rx_rst_n) begin
            rx_pma_parallel_data <= '0;
            rx_parallel_data_pma <= idle_fill;
        end else begin
            rx_pma_parallel_data <= gate_16g ? '0 : inv_q;
            rx_parallel_data_pma <= gate_8g ? idle_fill : inv_q;
        end
    end

    // the two rates never both carry live data
    a_one_output_gated : assert property (
        @(posedge rx_pma_clkout) disable iff (!rx_rst_n)
        (rx_pma_parallel_data == '0) || (rx_parallel_data_pma == idle_fill)
    ) else $error("16G and 8G outputs both ungated");

endmodule

//--- hdl/pma_rx_regs.sv
// control, status and scratch registers with a registered read port
`timescale 1ns/1ps
`include "pma_rx_settings.svh"

module pma_rx_regs (
    input  logic                           rx_pma_clkout,
    input  logic                           rx_rst_n,
    input  logic                           wr_en,
    input  logic                           rd_en,
    input  pma_rx_regs_pkg::pma_reg_addr_e addr,
    input  logic [`PMA_WORD_W-1:0]         wr_data,
    input  pma_rx_types_pkg::pma_status_t  status,
    output pma_rx_regs_pkg::pma_ctl_t      ctl,
    output logic [`PMA_WORD_W-1:0]         rd_data,
    output logic                           rd_data_v
);

    localparam int ctl_w    = $bits(pma_rx_regs_pkg::pma_ctl_t);
    localparam int status_w = $bits(pma_rx_types_pkg::pma_status_t);

    logic [`PMA_WORD_W-1:0] scratch_q;
    logic [`PMA_WORD_W-1:0] rd_mux;

    // ------------------------------
    // write side
    // ------------------------------
    always_ff @(posedge rx_pma_clkout or negedge rx_rst_n) begin
        if (!rx_rst_n) begin
            ctl <= '0;
        end else if (wr_en && (addr == pma_rx_regs_pkg::reg_ctl)) begin
            ctl <= pma_rx_regs_pkg::pma_ctl_t'(wr_data[ctl_w-1:0]);
        end
    end

    always_ff @(posedge rx_pma_clkout) begin
        if (wr_en && (addr == pma_rx_regs_pkg::reg_scratch)) begin
            scratch_q <= wr_data;
        end
    end

    // status writes fall through, nothing to update

    // ------------------------------
    // read side
    // ------------------------------
    always_comb begin
        case (addr)
            pma_rx_regs_pkg::reg_ctl:     rd_mux = {{(`PMA_WORD_W-ctl_w){1'b0}}, ctl};
            pma_rx_regs_pkg::reg_status:  rd_mux = {{(`PMA_WORD_W-status_w){1'b0}}, status};
            pma_rx_regs_pkg::reg_scratch: rd_mux = scratch_q;
            default:                      rd_mux = '0;   // holes read zero
        endcase
    end

    always_ff @(posedge rx_pma_clkout) begin
        if (rd_en) begin
            rd_data <= rd_mux;
        end
    end

    always_ff @(posedge rx_pma_clkout or negedge rx_rst_n) begin
        if (!rx_rst_n) begin
            rd_data_v <= 1'b0;
        end else begin
            rd_data_v <= rd_en;     // one cycle read latency
        end
    end

    a_rd_valid_follows_en : assert property (
        @(posedge rx_pma_clkout) disable iff (!rx_rst_n)
        rd_data_v |-> $past(rd_en)
    ) else $error("rd_data_v without a read request");

endmodule

//--- hdl/pma_rx_top.sv
// rx PHY top: pin and reset synchronizers, lock qualifier, datapath, registers
`timescale 1ns/1ps
`include "pma_rx_settings.svh"

module pma_rx_top #(
    parameter int lock_bits = `PMA_LOCK_BITS
) (
    input  logic                          rx_pma_clkout,     // recovered clock
    input  logic                          rx_rst_n,
    input  pma_rx_types_pkg::pma_word_t   rx_data_phy,
    input  logic [3:0]                    data_rate,         // bit 2 selects 16G
    input  logic                          sfp_los,
    input  logic                          cfg_rx_invert,
    input  logic                          rx_analogreset,
    input  logic                          rx_digitalreset,
    input  logic                          wr_en,
    input  logic                          rd_en,
    input  logic [`PMA_ADDR_W-1:0]        addr,
    input  logic [`PMA_WORD_W-1:0]        wr_data,
    output pma_rx_types_pkg::pma_word_t   rx_pma_parallel_data,
    output pma_rx_types_pkg::pma_word_t   rx_parallel_data_pma,
    output logic                          locked_to_data,
    output logic [`PMA_WORD_W-1:0]        rd_data,
    output logic                          rd_data_v
);

    logic                            los_sync;
    logic                            rate_bit_sync;
    logic                            invert_pin_sync;
    logic                            loslock_sync;
    logic                            locked;
    pma_rx_types_pkg::pma_rate_e     rate_sync;
    pma_rx_types_pkg::pma_status_t   status;
    pma_rx_regs_pkg::pma_ctl_t       ctl;

    // ------------------------------
    // synchronizers
    // ------------------------------
    // los resets high so both outputs start gated
    pma_rx_sync #(.width(3), .reset_value(3'b100)) i_pin_sync (
        .rx_pma_clkout (rx_pma_clkout),
        .rx_rst_n      (rx_rst_n),
        .in_level      ({sfp_los, data_rate[2], cfg_rx_invert}),
        .out_level     ({los_sync, rate_bit_sync, invert_pin_sync})
    );

    pma_rx_sync #(.width(1), .reset_value(1'b0)) i_loslock_sync (
        .rx_pma_clkout (rx_pma_clkout),
        .rx_rst_n      (rx_rst_n),
        .in_level      (rx_analogreset | rx_digitalreset),
        .out_level     (loslock_sync)
    );

    assign rate_sync = pma_rx_types_pkg::pma_rate_e'(rate_bit_sync);
    assign status    = pma_rx_types_pkg::pma_status_t'{
        locked: locked,
        los:    los_sync,
        rate:   rate_sync
    };
    assign locked_to_data = locked;

    // ------------------------------
    // lock, data, registers
    // ------------------------------
    pma_rx_lock_qual #(.lock_bits(lock_bits)) i_lock_qual (
        .rx_pma_clkout (rx_pma_clkout),
        .rx_rst_n      (rx_rst_n),
        .loslock       (loslock_sync),
        .ctl           (ctl),
        .locked        (locked)
    );

    pma_rx_datapath i_datapath (
        .rx_pma_clkout        (rx_pma_clkout),
        .rx_rst_n             (rx_rst_n),
        .rx_data_phy          (rx_data_phy),
        .ctl                  (ctl),
        .invert_pin           (invert_pin_sync),
        .status               (status),
        .rx_pma_parallel_data (rx_pma_parallel_data),
        .rx_parallel_data_pma (rx_parallel_data_pma)
    );

    pma_rx_regs i_regs (
        .rx_pma_clkout (rx_pma_clkout),
        .rx_rst_n      (rx_rst_n),
        .wr_en         (wr_en),
        .rd_en         (rd_en),
        .addr          (pma_rx_regs_pkg::pma_reg_addr_e'(addr)),
        .wr_data       (wr_data),
        .status        (status),
        .ctl           (ctl),
        .rd_data       (rd_data),
        .rd_data_v     (rd_data_v)
    );

endmodule

//--- tb/tb_pma_rx.sv
// testbench for the rx PHY top: clock, stimulus, reference model, checking assertions, report
`timescale 1ns/1ps
`include "pma_rx_settings.svh"

module tb_pma_rx;

    localparam int lock_bits      = 6;
    localparam int lock_wait      = 2 ** (lock_bits - 1) + 4;
    localparam int lock_delay     = 2 ** (lock_bits - 1) + 1;   // edges from hold low to lock
    localparam int timeout_cycles = 6 * (2 ** lock_bits + 64);
    // low 40 bits hold four alternating D21.5 chars and the top 24 stay zero
    localparam logic [`PMA_WORD_W-1:0] idle_fill = 64'h0000_00aa_aaaa_aaaa;

    logic                   rx_pma_clkout;
    logic                   rx_rst_n;
    logic [`PMA_WORD_W-1:0] rx_data_phy = '0;
    logic [3:0]             data_rate;
    logic                   sfp_los;
    logic                   cfg_rx_invert;
    logic                   rx_analogreset;
    logic                   rx_digitalreset;
    logic                   wr_en;
    logic                   rd_en;
    logic [`PMA_ADDR_W-1:0] addr;
    logic [`PMA_WORD_W-1:0] wr_data;
    logic [`PMA_WORD_W-1:0] rx_pma_parallel_data;
    logic [`PMA_WORD_W-1:0] rx_parallel_data_pma;
    logic                   locked_to_data;
    logic [`PMA_WORD_W-1:0] rd_data;
    logic                   rd_data_v;

    // reference model state
    logic [1:0]             los_sq;     // two-flop delay, [1] is the synced value
    logic [1:0]             rate_sq;
    logic [1:0]             inv_sq;
    logic [1:0]             reset_sq;
    logic                   ctl_invert_m;
    logic                   ctl_restart_m;
    int                     lock_cnt;
    logic                   locked_m;
    logic                   hold_m;
    logic                   gate_16g_m;
    logic                   gate_8g_m;
    logic [`PMA_WORD_W-1:0] w1_m;
    logic [`PMA_WORD_W-1:0] w2_m;
    logic [`PMA_WORD_W-1:0] exp_16g;
    logic [`PMA_WORD_W-1:0] exp_8g;
    logic [`PMA_WORD_W-1:0] exp_rd;
    logic [`PMA_WORD_W-1:0] scratch_m;
    logic                   rdv_m;

    logic [63:0] rng_state     = 64'd92;
    int          assert_errors = 0;
    int          check_errors  = 0;
    int          cycle_cnt     = 0;
    int          tests_run     = 0;
    int          tests_failed  = 0;
    int          err_mark      = 0;

    pma_rx_top #(.lock_bits(lock_bits)) i_dut (
        .rx_pma_clkout        (rx_pma_clkout),
        .rx_rst_n             (rx_rst_n),
        .rx_data_phy          (rx_data_phy),
        .data_rate            (data_rate),
        .sfp_los              (sfp_los),
        .cfg_rx_invert        (cfg_rx_invert),
        .rx_analogreset       (rx_analogreset),
        .rx_digitalreset      (rx_digitalreset),
        .wr_en                (wr_en),
        .rd_en                (rd_en),
        .addr                 (addr),
        .wr_data              (wr_data),
        .rx_pma_parallel_data (rx_pma_parallel_data),
        .rx_parallel_data_pma (rx_parallel_data_pma),
        .locked_to_data       (locked_to_data),
        .rd_data              (rd_data),
        .rd_data_v            (rd_data_v)
    );

    initial begin
        rx_pma_clkout = 1'b0;
        forever #5 rx_pma_clkout = ~rx_pma_clkout;
    end

    function automatic logic [63:0] xorshift64(input logic [63:0] s);
        logic [63:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    // new word every cycle, no back-pressure
    always @(negedge rx_pma_clkout) begin
        rng_state = xorshift64(rng_state);
        rx_data_phy <= rng_state;
    end

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic logic [`PMA_WORD_W-1:0] expected_read(input logic [`PMA_ADDR_W-1:0] a);
        case (a)
            pma_rx_regs_pkg::reg_ctl:     return {{(`PMA_WORD_W-2){1'b0}}, ctl_restart_m,
                                                  ctl_invert_m};
            pma_rx_regs_pkg::reg_status:  return {{(`PMA_WORD_W-3){1'b0}}, locked_m,
                                                  los_sq[1], rate_sq[1]};
            pma_rx_regs_pkg::reg_scratch: return scratch_m;
            default:                      return '0;
        endcase
    endfunction

    assign locked_m   = (lock_cnt == lock_delay);
    assign hold_m     = reset_sq[1] | ctl_restart_m;
    assign gate_16g_m = !locked_m || los_sq[1] || !rate_sq[1];
    assign gate_8g_m  = !locked_m || los_sq[1] || rate_sq[1];

    always @(posedge rx_pma_clkout or negedge rx_rst_n) begin
        if (!rx_rst_n) begin
            los_sq        <= 2'b11;     // los starts asserted
            rate_sq       <= 2'b00;
            inv_sq        <= 2'b00;
            reset_sq      <= 2'b00;
            ctl_invert_m  <= 1'b0;
            ctl_restart_m <= 1'b0;
            lock_cnt      <= 0;
            exp_16g       <= '0;
            exp_8g        <= idle_fill;
            rdv_m         <= 1'b0;
        end else begin
            los_sq   <= {los_sq[0], sfp_los};
            rate_sq  <= {rate_sq[0], data_rate[2]};
            inv_sq   <= {inv_sq[0], cfg_rx_invert};
            reset_sq <= {reset_sq[0], rx_analogreset | rx_digitalreset};
            if (wr_en && addr == pma_rx_regs_pkg::reg_ctl) begin
                ctl_invert_m  <= wr_data[0];
                ctl_restart_m <= wr_data[1];
            end
            if (wr_en && addr == pma_rx_regs_pkg::reg_scratch) begin
                scratch_m <= wr_data;
            end
            if (hold_m) begin
                lock_cnt <= 0;
            end else if (!locked_m) begin
                lock_cnt <= lock_cnt + 1;
            end
            exp_16g <= gate_16g_m ? '0 : w2_m;
            exp_8g  <= gate_8g_m ? idle_fill : w2_m;
            rdv_m   <= rd_en;
            if (rd_en) begin
                exp_rd <= expected_read(addr);
            end
        end
    end

    always @(posedge rx_pma_clkout) begin
        w1_m <= rx_data_phy;
        w2_m <= (inv_sq[1] ^ ctl_invert_m) ? ~w1_m : w1_m;   // one inversion source flips
    end

    // ------------------------------
    // checking assertions
    // ------------------------------
    a_reset_state : assert property (@(posedge rx_pma_clkout)
        $rose(rx_rst_n) |-> (!locked_to_data && !rd_data_v && rx_pma_parallel_data == '0
                             && rx_parallel_data_pma == idle_fill))
    else begin
        assert_errors++;
        $display("Fail at %0d ns: outputs not in their reset state", $time);
    end

    a_lock_match : assert property (@(posedge rx_pma_clkout) disable iff (!rx_rst_n)
        locked_to_data == locked_m)
    else begin
        assert_errors++;
        $display("Fail at %0d ns: locked_to_data is %b, expected %b", $time,
                 locked_to_data, locked_m);
    end

    a_lock_drop : assert property (@(posedge rx_pma_clkout) disable iff (!rx_rst_n)
        hold_m |=> !locked_to_data)
    else begin
        assert_errors++;
        $display("Fail at %0d ns: lock not dropped after hold", $time);
    end

    a_out_16g : assert property (@(posedge rx_pma_clkout) disable iff (!rx_rst_n)
        rx_pma_parallel_data == exp_16g)
    else begin
        assert_errors++;
        $display("Fail at %0d ns: 16G output %h, expected %h", $time,
                 rx_pma_parallel_data, exp_16g);
    end

    a_out_8g : assert property (@(posedge rx_pma_clkout) disable iff (!rx_rst_n)
        rx_parallel_data_pma == exp_8g)
    else begin
        assert_errors++;
        $display("Fail at %0d ns: 8G output %h, expected %h", $time,
                 rx_parallel_data_pma, exp_8g);
    end

    a_rd_valid : assert property (@(posedge rx_pma_clkout) disable iff (!rx_rst_n)
        rd_data_v == rdv_m)
    else begin
        assert_errors++;
        $display("Fail at %0d ns: rd_data_v is %b, expected %b", $time, rd_data_v, rdv_m);
    end

    a_rd_data : assert property (@(posedge rx_pma_clkout) disable iff (!rx_rst_n)
        rdv_m |-> rd_data == exp_rd)
    else begin
        assert_errors++;
        $display("Fail at %0d ns: rd_data %h, expected %h", $time, rd_data, exp_rd);
    end

    // ------------------------------
    // stimulus tasks
    // ------------------------------
    // all tasks start and end on a falling edge
    task automatic wait_cycles(input int n);
        repeat (n) @(negedge rx_pma_clkout);
    endtask

    task automatic wait_lock(input logic level, input int limit);
        int n;
        n = 0;
        while (locked_to_data !== level && n < limit) begin
            @(negedge rx_pma_clkout);
            n++;
        end
        if (locked_to_data !== level) begin
            check_errors++;
            $display("locked_to_data did not go to %b within %0d cycles", level, limit);
        end
    endtask

    task automatic write_reg(input logic [`PMA_ADDR_W-1:0] a, input logic [63:0] d);
        wr_en   = 1'b1;
        addr    = a;
        wr_data = d;
        @(negedge rx_pma_clkout);
        wr_en   = 1'b0;
    endtask

    task automatic read_reg(input logic [`PMA_ADDR_W-1:0] a);
        int n;
        rd_en = 1'b1;
        addr  = a;
        @(negedge rx_pma_clkout);
        rd_en = 1'b0;
        n = 0;
        while (!rd_data_v && n < 2) begin
            @(negedge rx_pma_clkout);
            n++;
        end
        if (!rd_data_v) begin
            check_errors++;
            $display("no read response for address %0d", a);
        end
        @(negedge rx_pma_clkout);
    endtask

    task automatic start_test();
        err_mark = assert_errors + check_errors;
    endtask

    task automatic end_test(input string name);
        int delta;
        delta = assert_errors + check_errors - err_mark;
        tests_run++;
        if (delta > 0) begin
            tests_failed++;
            $display("test %s: %0d errors", name, delta);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // run limit
    always @(posedge rx_pma_clkout) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        rx_rst_n        = 1'b0;
        data_rate       = 4'b0100;      // 16G
        sfp_los         = 1'b0;
        cfg_rx_invert   = 1'b0;
        rx_analogreset  = 1'b0;
        rx_digitalreset = 1'b0;
        wr_en           = 1'b0;
        rd_en           = 1'b0;
        addr            = '0;
        wr_data         = '0;
        wait_cycles(4);
        rx_rst_n = 1'b1;

        start_test();
        wait_cycles(2);
        end_test("reset state");

        start_test();
        wait_lock(1'b1, lock_wait);
        rx_digitalreset = 1'b1;
        wait_lock(1'b0, 3);
        rx_digitalreset = 1'b0;
        wait_lock(1'b1, lock_wait);
        rx_analogreset = 1'b1;
        wait_lock(1'b0, 3);
        rx_analogreset = 1'b0;
        wait_lock(1'b1, lock_wait);
        write_reg(pma_rx_regs_pkg::reg_ctl, 64'd2);    // lock_restart
        wait_lock(1'b0, 3);
        write_reg(pma_rx_regs_pkg::reg_ctl, 64'd0);
        wait_lock(1'b1, lock_wait);
        end_test("lock qualification");

        start_test();
        wait_cycles(24);
        end_test("16G steering");

        start_test();
        data_rate = 4'b0000;
        wait_cycles(24);
        sfp_los = 1'b1;
        wait_cycles(8);
        sfp_los = 1'b0;
        wait_cycles(8);
        end_test("8G steering and los");

        start_test();
        data_rate = 4'b0100;
        wait_cycles(6);
        cfg_rx_invert = 1'b1;
        wait_cycles(8);
        write_reg(pma_rx_regs_pkg::reg_ctl, 64'd1);    // both set, no inversion
        wait_cycles(8);
        cfg_rx_invert = 1'b0;
        wait_cycles(8);
        write_reg(pma_rx_regs_pkg::reg_ctl, 64'd0);
        wait_cycles(6);
        end_test("polarity");

        start_test();
        write_reg(pma_rx_regs_pkg::reg_scratch, 64'h5a3c_96e1_0f87_d24b);
        read_reg(pma_rx_regs_pkg::reg_scratch);
        write_reg(pma_rx_regs_pkg::reg_status, '1);    // ignored
        read_reg(pma_rx_regs_pkg::reg_status);
        sfp_los = 1'b1;
        wait_cycles(4);
        read_reg(pma_rx_regs_pkg::reg_status);
        sfp_los = 1'b0;
        wait_cycles(4);
        read_reg(4'd7);
        read_reg(pma_rx_regs_pkg::reg_ctl);
        end_test("registers");

        $display("tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
                 assert_errors + check_errors);
        if (tests_failed == 0 && assert_errors + check_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- pma_rx.f
+incdir+hdl
hdl/pma_rx_types_pkg.sv
hdl/pma_rx_regs_pkg.sv
hdl/pma_rx_sync.sv
hdl/pma_rx_lock_qual.sv
hdl/pma_rx_datapath.sv
hdl/pma_rx_regs.sv
hdl/pma_rx_top.sv
tb/tb_pma_rx.sv

//--- run_sim.sh
#!/bin/sh
# builds the rx PHY testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f pma_rx.f \
    --top-module tb_pma_rx \
    -o sim_tb_pma_rx

# the log decides the result, so a nonzero exit from the run is not fatal here
./obj_dir/sim_tb_pma_rx > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "run failed, see sim.log"
    exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
    echo "run ended without a result, see sim.log"
    exit 1
fi
echo "run passed"
